//--- Makefile
TOOL     = verilator
VFLAGS   = --binary --timing --assert
TOP      = rename_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/rename_cases.svh
// Table rows of name, operation, CDB entry, retire pair, dispatch pair and expected bundle

	add_row("idle_start", op_idle, '0, '0, '0, '0);
	// Identity map after reset and dest tags from the head of the free list
	add_row("reset_pair", op_dispatch, '0, '0,
		pair(reg_instr(2, 3, 5), reg_instr(6, 7, 8)),
		bundle(slot(1, 2, 1, 3, 1, 5, 32, 5), slot(1, 6, 1, 7, 1, 8, 33, 8)));
	add_row("read_new", op_dispatch, '0, '0,
		pair(reg_instr(5, 8, 9), reg_instr(8, 1, 10)),
		bundle(slot(1, 32, 0, 33, 0, 9, 34, 9), slot(1, 33, 0, 1, 1, 10, 35, 10)));
	add_row("cdb_stale", op_cdb, broadcast(5, 5), '0, '0, '0);  // r5 lives in 32 now
	add_row("after_stale", op_dispatch, '0, '0,
		pair(reg_instr(5, 0, 11), '0),
		bundle(slot(1, 32, 0, 0, 1, 11, 36, 11), empty_slot()));
	add_row("cdb_wake", op_cdb, broadcast(5, 32), '0, '0, '0);
	add_row("woken", op_dispatch, '0, '0,
		pair(reg_instr(5, 9, 12), '0),
		bundle(slot(1, 32, 1, 34, 0, 12, 37, 12), empty_slot()));
	// Both slot 1 sources take slot 0's new tag
	add_row("bypass", op_dispatch, '0, '0,
		pair(reg_instr(1, 2, 13), reg_instr(13, 13, 14)),
		bundle(slot(1, 1, 1, 2, 1, 13, 38, 13), slot(1, 38, 0, 38, 0, 14, 39, 14)));
	add_row("same_dest", op_dispatch, '0, '0,
		pair(reg_instr(3, 4, 15), reg_instr(6, 7, 15)),
		bundle(slot(1, 3, 1, 4, 1, 15, 40, 15), slot(1, 6, 1, 7, 1, 15, 41, 40)));
	// Immediate and PC operands read as tag 0
	add_row("read_same", op_dispatch, '0, '0,
		pair(instr(1, opa_is_rega, opb_is_imm, 15, 7, 16),
		instr(1, opa_is_pc, opb_is_regb, 9, 0, 17)),
		bundle(slot(1, 41, 0, 0, 1, 16, 42, 16), slot(1, 0, 1, 0, 1, 17, 43, 17)));
	// Zero dest allocates nothing but still reads its register sources
	add_row("zero_dest", op_dispatch, '0, '0,
		pair(reg_instr(1, 2, 0), reg_instr(16, 2, 18)),
		bundle(slot(0, 1, 1, 2, 1, 0, 0, 0), slot(1, 42, 0, 2, 1, 18, 44, 18)));
	add_row("retire_first", op_retire, '0, retire_pair(5, 32, 5, 8, 33, 8), '0, '0);
	// Pair still in flight when the flush hits
	add_row("flush_inflight", op_recover, '0, '0, pair(reg_instr(1, 2, 20), '0), '0);
	add_row("after_recover", op_dispatch, '0, '0,
		pair(reg_instr(5, 8, 9), reg_instr(13, 10, 21)),
		bundle(slot(1, 32, 1, 33, 1, 9, 34, 9), slot(1, 13, 1, 10, 1, 21, 35, 21)));

//--- dv/rename_tb.sv
// Rename stage testbench with clock, reset, row table loop, random allocation run and watchdog

module rename_tb;

	import rename_pkg::*;
	import cdb_pkg::*;

	localparam int num_pr       = 96;
	localparam int cdb_width    = 4;
	localparam int period       = 100;
	localparam int reset_cycles = 8;
	localparam int random_pairs = 48;  // Enough allocations to wrap the 64 free tags

	typedef enum logic [2:0]
	{
		op_idle,
		op_dispatch,
		op_cdb,
		op_retire,
		op_recover
	} op_e;

	typedef retire_entry_t [1:0] retire_pair_t;

	// Wide enough for a whole renamed bundle
	typedef logic [$bits(rename_out_t)-1:0] value_t;

	// One table row with stimulus and the bundle expected 2 cycles later
	typedef struct packed
	{
		op_e          op;
		cdb_entry_t   cdb;
		retire_pair_t retire;
		dispatch_t    disp;
		rename_out_t  expected;
	} row_t;

	logic                        clock;
	logic                        reset;
	logic                        dispatch_strobe;
	logic                        recover;
	logic                        rename_strobe;
	dispatch_t                   dispatch;
	cdb_entry_t [cdb_width-1:0]  cdb;
	retire_pair_t                retire;
	rename_out_t                 rename;

	row_t  rows[$];
	string names[$];
	int    seed = 32'h16a73471;

	rename_top #(.num_pr(num_pr), .cdb_width(cdb_width)) dut0
	(
		.clock           (clock),
		.reset           (reset),
		.dispatch_strobe (dispatch_strobe),
		.dispatch        (dispatch),
		.cdb             (cdb),
		.retire          (retire),
		.recover         (recover),
		.rename_strobe   (rename_strobe),
		.rename          (rename)
	);

	initial
	begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	// ################################################
	// Row builders

	function automatic rename_req_t instr(input int v, input opa_sel_e opa, input opb_sel_e opb,
		input int a, input int b, input int d);
		rename_req_t r;
		r.valid = (v != 0);
		r.opa_sel = opa;
		r.opb_sel = opb;
		r.src_a = arch_reg_t'(a);
		r.src_b = arch_reg_t'(b);
		r.dest = arch_reg_t'(d);
		return r;
	endfunction

	function automatic rename_req_t reg_instr(input int a, input int b, input int d);
		return instr(1, opa_is_rega, opb_is_regb, a, b, d);
	endfunction

	function automatic dispatch_t pair(input rename_req_t s0, input rename_req_t s1);
		dispatch_t p;
		p.slot0 = s0;
		p.slot1 = s1;
		return p;
	endfunction

	function automatic rename_slot_t slot(input int v, input int at, input int a_rdy,
		input int bt, input int b_rdy, input int d, input int dt, input int told);
		rename_slot_t s;
		s.valid = (v != 0);
		s.src_a_tag = phys_tag_t'(at);
		s.src_a_ready = (a_rdy != 0);
		s.src_b_tag = phys_tag_t'(bt);
		s.src_b_ready = (b_rdy != 0);
		s.dest = arch_reg_t'(d);
		s.dest_tag = phys_tag_t'(dt);
		s.told_tag = phys_tag_t'(told);
		return s;
	endfunction

	// Unused slot reads r0 as tag 0 and ready
	function automatic rename_slot_t empty_slot();
		return slot(0, 0, 1, 0, 1, 0, 0, 0);
	endfunction

	function automatic rename_out_t bundle(input rename_slot_t s0, input rename_slot_t s1);
		rename_out_t b;
		b.slot0 = s0;
		b.slot1 = s1;
		return b;
	endfunction

	function automatic cdb_entry_t broadcast(input int ar, input int pr);
		cdb_entry_t c;
		c.valid = 1'b1;
		c.ar = arch_reg_t'(ar);
		c.pr = phys_tag_t'(pr);
		return c;
	endfunction

	function automatic retire_entry_t retire_entry(input int ar, input int pr, input int told);
		retire_entry_t e;
		e.valid = 1'b1;
		e.ar = arch_reg_t'(ar);
		e.pr = phys_tag_t'(pr);
		e.told = phys_tag_t'(told);
		return e;
	endfunction

	function automatic retire_pair_t retire_pair(input int ar0, input int pr0, input int told0,
		input int ar1, input int pr1, input int told1);
		retire_pair_t p;
		p[0] = retire_entry(ar0, pr0, told0);  // Older instruction
		p[1] = retire_entry(ar1, pr1, told1);
		return p;
	endfunction

	function automatic void add_row(input string name, input op_e op, input cdb_entry_t c,
		input retire_pair_t ret, input dispatch_t disp, input rename_out_t expected);
		row_t r;
		r.op = op;
		r.cdb = c;
		r.retire = ret;
		r.disp = disp;
		r.expected = expected;
		rows.push_back(r);
		names.push_back(name);
	endfunction

	function automatic void load_cases();
		`include "rename_cases.svh"
	endfunction

	// ################################################
	// Drivers and checks

	task automatic check_value(input string name, input value_t expected,
		input value_t actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic apply_row(input int i);
		row_t       r;
		logic [1:0] port;
		r = rows[i];
		port = 2'(i % cdb_width);  // Spread broadcasts over the CDB ports
		case (r.op)
			op_dispatch:
			begin
				dispatch = r.disp;
				dispatch_strobe = 1'b1;
				@(negedge clock);
				dispatch_strobe = 1'b0;
				dispatch = '0;
				@(negedge clock);  // Fixed 2 cycle latency
				check_value({names[i], " strobe"}, value_t'(1), value_t'(rename_strobe));
				check_value(names[i], value_t'(r.expected), value_t'(rename));
			end
			op_cdb:
			begin
				cdb[port] = r.cdb;
				@(negedge clock);
				cdb = '0;
			end
			op_retire:
			begin
				retire = r.retire;
				@(negedge clock);
				retire = '0;
			end
			op_recover:
			begin
				// Optional pair goes in one cycle ahead of the flush
				dispatch = r.disp;
				dispatch_strobe = r.disp.slot0.valid;
				@(negedge clock);
				dispatch_strobe = 1'b0;
				dispatch = '0;
				recover = 1'b1;
				@(negedge clock);
				recover = 1'b0;
				check_value({names[i], " strobe"}, value_t'(0), value_t'(rename_strobe));
			end
			default:
				@(negedge clock);
		endcase
	endtask

	// Model keeps the free list as a FIFO of tags and the map as a plain array
	task automatic random_run();
		phys_tag_t     free_tags[$];
		phys_tag_t     spec_model [32];
		retire_entry_t in_flight[$];
		int            d0;
		int            d1;
		phys_tag_t     t0;
		phys_tag_t     t1;
		phys_tag_t     told0;
		phys_tag_t     told1;
		string         name;
		for (int r = 0; r < 32; r++)
			spec_model[r] = phys_tag_t'(r);
		for (int t = 32; t < num_pr; t++)
			free_tags.push_back(phys_tag_t'(t));
		for (int n = 0; n < random_pairs; n++)
		begin
			name = $sformatf("random_pair_%0d", n);
			d0 = 1 + int'($unsigned($random(seed)) % 31);
			d1 = 1 + int'($unsigned($random(seed)) % 31);
			t0 = free_tags.pop_front();
			told0 = spec_model[arch_reg_t'(d0)];
			spec_model[arch_reg_t'(d0)] = t0;
			t1 = free_tags.pop_front();
			told1 = spec_model[arch_reg_t'(d1)];  // Equal dests see t0 here
			spec_model[arch_reg_t'(d1)] = t1;
			in_flight.push_back(retire_entry(d0, int'(t0), int'(told0)));
			in_flight.push_back(retire_entry(d1, int'(t1), int'(told1)));

			dispatch = pair(instr(1, opa_is_zero, opb_is_zero, 0, 0, d0),
				instr(1, opa_is_zero, opb_is_zero, 0, 0, d1));
			dispatch_strobe = 1'b1;
			@(negedge clock);
			dispatch_strobe = 1'b0;
			dispatch = '0;
			@(negedge clock);
			check_value({name, " strobe"}, value_t'(1), value_t'(rename_strobe));
			check_value(name, value_t'({t0, told0, t1, told1}),
				value_t'({rename.slot0.dest_tag, rename.slot0.told_tag,
				rename.slot1.dest_tag, rename.slot1.told_tag}));

			// Retire oldest two once a few pairs are in flight
			if (in_flight.size() > 6)
			begin
				retire[0] = in_flight.pop_front();
				retire[1] = in_flight.pop_front();
				free_tags.push_back(retire[0].told);
				free_tags.push_back(retire[1].told);
				@(negedge clock);
				retire = '0;
			end
		end
	endtask

	// ################################################
	// Main sequence and watchdog

	initial
	begin
		reset = 1'b1;
		dispatch_strobe = 1'b0;
		dispatch = '0;
		cdb = '0;
		retire = '0;
		recover = 1'b0;
		load_cases();
		apply_reset();
		for (int i = 0; i < rows.size(); i++)
			apply_row(i);
		apply_reset();  // Random run starts from a clean map and free list
		random_run();
		$display("All tests passed");
		$finish;
	end

	initial
	begin
		int limit;
		#1;
		limit = (rows.size() * 4 + random_pairs * 4 + 2 * reset_cycles + 10) * period;
		#(limit);
		$display("Watchdog expired after %0d time units, the run did not finish", limit);
		$display("Some tests failed");
		$fatal(1);
	end

endmodule

//--- hw/cdb_pkg.sv
// Completion broadcast and retirement entry types

package cdb_pkg;

	// Dest mapping of a completing instruction on one CDB port
	typedef struct packed
	{
		logic                  valid;
		rename_pkg::arch_reg_t ar;
		rename_pkg::phys_tag_t pr;
	} cdb_entry_t;

	// One retiring instruction from the ROB
	typedef struct packed
	{
		logic                  valid;
		rename_pkg::arch_reg_t ar;
		rename_pkg::phys_tag_t pr;    // New committed mapping of ar
		rename_pkg::phys_tag_t told;  // Tag that goes back to the free list
	} retire_entry_t;

endpackage

//--- hw/free_list.sv
// Circular free list of physical tags with allocate, reclaim and rewind

module free_list
#(
	parameter int num_pr = 96
)
(
	input  logic                             clock,
	input  logic                             reset,
	input  logic                             recover,
	input  logic                             decode_valid,
	input  rename_pkg::dispatch_t            stage,
	input  cdb_pkg::retire_entry_t [1:0]     retire,
	output rename_pkg::phys_tag_t            new_tag0,
	output rename_pkg::phys_tag_t            new_tag1
);

	import rename_pkg::*;

	localparam int depth   = num_pr - 32;  // Tags beyond the initial identity map
	localparam int ptr_w   = $clog2(depth);
	localparam int count_w = $clog2(depth + 1);

	phys_tag_t          tags [depth];
	logic [ptr_w-1:0]   head;         // Next tag to allocate
	logic [ptr_w-1:0]   tail;         // Next slot for a reclaimed tag
	logic [ptr_w-1:0]   rewind;       // Oldest allocation not yet retired
	logic [count_w-1:0] free_count;

	logic [1:0]         alloc_num;
	logic [1:0]         push_num;
	logic [ptr_w-1:0]   next_rewind;

	// Pointer add with wrap at depth, which need not be a power of two
	function automatic logic [ptr_w-1:0] ptr_add(input logic [ptr_w-1:0] p,
		input logic [1:0] n);
		logic [ptr_w:0] sum;
		sum = (ptr_w+1)'(p) + (ptr_w+1)'(n);
		if (sum >= (ptr_w+1)'(depth))
			sum = sum - (ptr_w+1)'(depth);
		return ptr_w'(sum);
	endfunction

	assign alloc_num = decode_valid ? 2'(stage.slot0.valid) + 2'(stage.slot1.valid) : 2'd0;
	assign push_num = 2'(retire[0].valid) + 2'(retire[1].valid);
	assign next_rewind = ptr_add(rewind, push_num);

	// Slot 1 takes the next tag only if slot 0 used the head
	assign new_tag0 = tags[head];
	assign new_tag1 = stage.slot0.valid ? tags[ptr_add(head, 2'd1)] : tags[head];

	// ################################################
	// Pointers and count

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			rewind <= '0;
			free_count <= count_w'(depth);
		end
		else
		begin
			tail <= ptr_add(tail, push_num);
			rewind <= next_rewind;
			if (recover)
			begin
				head <= next_rewind;  // Drop every unretired allocation
				free_count <= count_w'(depth);
			end
			else
			begin
				head <= ptr_add(head, alloc_num);
				free_count <= free_count - count_w'(alloc_num) + count_w'(push_num);
			end
		end
	end

	// ################################################
	// Tag storage

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < depth; i++)
				tags[i] <= phys_tag_t'(32 + i);  // Tags 32 and up are free at start
		end
		else
		begin
			if (retire[0].valid)
				tags[tail] <= retire[0].told;
			if (retire[1].valid)
				tags[ptr_add(tail, 2'(retire[0].valid))] <= retire[1].told;
		end
	end

	// Feeder keeps in-flight dests within the free count
	a_no_underflow: assert property (@(posedge clock) disable iff (reset)
		!recover |-> (count_w'(alloc_num) <= free_count))
		else $error("free list underflow");

	// A retire implies an in-flight tag, so the list has room
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		(free_count + count_w'(push_num)) <= count_w'(depth))
		else $error("free list overflow");

endmodule

//--- hw/map_table.sv
// Map table with speculative and retirement maps, ready bits, CDB wakeup and intra-pair bypass

module map_table
#(
	parameter int num_pr    = 96,
	parameter int cdb_width = 4
)
(
	input  logic                                  clock,
	input  logic                                  reset,
	input  logic                                  recover,
	input  logic                                  decode_valid,
	input  rename_pkg::dispatch_t                 stage,
	input  rename_pkg::phys_tag_t                 new_tag0,
	input  rename_pkg::phys_tag_t                 new_tag1,
	input  cdb_pkg::cdb_entry_t [cdb_width-1:0]   cdb,
	input  cdb_pkg::retire_entry_t [1:0]          retire,
	output rename_pkg::rename_out_t               result
);

	import rename_pkg::*;

	phys_tag_t   spec_map [32];
	phys_tag_t   ret_map [32];
	logic [31:0] ready;

	phys_tag_t   next_ret [32];
	logic [31:0] cdb_ready;   // Ready bits with this cycle's CDB applied
	logic [31:0] next_ready;

	rename_req_t s0;
	rename_req_t s1;
	logic        a1_bypass;
	logic        b1_bypass;
	logic        same_dest;
	logic        keep_dest0;

	assign s0 = stage.slot0;
	assign s1 = stage.slot1;

	// Slot 1 reads slot 0's result through the pair
	assign a1_bypass = s0.valid && (s1.src_a == s0.dest);
	assign b1_bypass = s0.valid && (s1.src_b == s0.dest);
	assign same_dest = s0.valid && s1.valid && (s1.dest == s0.dest);
	assign keep_dest0 = s0.valid && !same_dest;  // Younger write wins

	// ################################################
	// CDB wakeup and ready update

	always_comb
	begin
		cdb_ready = ready;
		for (int i = 0; i < cdb_width; i++)
		begin
			// Stale broadcasts for a remapped register are dropped
			if (cdb[i].valid && (spec_map[cdb[i].ar] == cdb[i].pr))
				cdb_ready[cdb[i].ar] = 1'b1;
		end
	end

	always_comb
	begin
		next_ready = cdb_ready;
		if (decode_valid && s0.valid)
			next_ready[s0.dest] = 1'b0;
		if (decode_valid && s1.valid)
			next_ready[s1.dest] = 1'b0;
	end

	always_comb
	begin
		next_ret = ret_map;
		for (int i = 0; i < 2; i++)
		begin
			if (retire[i].valid)
				next_ret[retire[i].ar] = retire[i].pr;
		end
	end

	// ################################################
	// Lookup

	always_comb
	begin
		result.slot0.valid = s0.valid;
		result.slot0.src_a_tag = spec_map[s0.src_a];
		result.slot0.src_a_ready = cdb_ready[s0.src_a];
		result.slot0.src_b_tag = spec_map[s0.src_b];
		result.slot0.src_b_ready = cdb_ready[s0.src_b];
		result.slot0.dest = s0.dest;
		result.slot0.dest_tag = s0.valid ? new_tag0 : '0;
		result.slot0.told_tag = s0.valid ? spec_map[s0.dest] : '0;

		result.slot1.valid = s1.valid;
		result.slot1.src_a_tag = a1_bypass ? new_tag0 : spec_map[s1.src_a];
		result.slot1.src_a_ready = !a1_bypass && cdb_ready[s1.src_a];
		result.slot1.src_b_tag = b1_bypass ? new_tag0 : spec_map[s1.src_b];
		result.slot1.src_b_ready = !b1_bypass && cdb_ready[s1.src_b];
		result.slot1.dest = s1.dest;
		result.slot1.dest_tag = s1.valid ? new_tag1 : '0;
		if (!s1.valid)
			result.slot1.told_tag = '0;
		else if (same_dest)
			result.slot1.told_tag = new_tag0;  // Slot 0's tag is freed by slot 1
		else
			result.slot1.told_tag = spec_map[s1.dest];
	end

	// ################################################
	// Map state

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
			begin
				spec_map[i] <= phys_tag_t'(i);  // Identity
				ret_map[i] <= phys_tag_t'(i);
			end
			ready <= '1;
		end
		else
		begin
			ret_map <= next_ret;
			if (recover)
			begin
				spec_map <= next_ret;
				ready <= '1;  // Everything committed has its value
			end
			else
			begin
				ready <= next_ready;
				if (decode_valid && keep_dest0)
					spec_map[s0.dest] <= new_tag0;
				if (decode_valid && s1.valid)
					spec_map[s1.dest] <= new_tag1;
			end
		end
	end

	// The zero register is never renamed, so the ROB cannot retire it
	a_retire0_not_zero: assert property (@(posedge clock) disable iff (reset)
		retire[0].valid |-> (retire[0].ar != zero_reg))
		else $error("retire of zero_reg on port 0");

	a_retire1_not_zero: assert property (@(posedge clock) disable iff (reset)
		retire[1].valid |-> (retire[1].ar != zero_reg))
		else $error("retire of zero_reg on port 1");

	// Tags handed to the pair must be real physical registers
	a_tag_range: assert property (@(posedge clock) disable iff (reset)
		(decode_valid && s0.valid) |-> (int'(new_tag0) < num_pr))
		else $error("allocated tag out of range");

endmodule

//--- hw/rename_decode.sv
// Rename input stage with the dispatch pair register and operand qualification

module rename_decode
(
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  recover,
	input  logic                  dispatch_strobe,
	input  rename_pkg::dispatch_t dispatch,
	output logic                  decode_valid,
	output rename_pkg::dispatch_t stage
);

	import rename_pkg::*;

	// Fold operand use into the selects and dest use into valid
	function automatic rename_req_t qualify(input rename_req_t req);
		rename_req_t q;
		q = req;
		q.valid = req.valid && (req.dest != zero_reg);
		if (!q.valid)
			q.dest = zero_reg;
		if (!req.valid)
		begin
			q.opa_sel = opa_is_zero;
			q.opb_sel = opb_is_zero;
		end
		if (q.opa_sel != opa_is_rega)
			q.src_a = zero_reg;  // Reads as tag 0 and ready
		if (q.opb_sel != opb_is_regb)
			q.src_b = zero_reg;
		return q;
	endfunction

	always_ff @(posedge clock)
	begin
		if (reset || recover)
			decode_valid <= 1'b0;
		else
			decode_valid <= dispatch_strobe;
	end

	// Qualified pair for the map table and the free list
	always_ff @(posedge clock)
	begin
		if (dispatch_strobe)
		begin
			stage.slot0 <= qualify(dispatch.slot0);
			stage.slot1 <= qualify(dispatch.slot1);
		end
	end

	// Pairs are packed from slot 0
	a_slot_order: assert property (@(posedge clock) disable iff (reset)
		dispatch_strobe |-> (dispatch.slot0.valid || !dispatch.slot1.valid))
		else $error("slot 1 dispatched without slot 0");

endmodule

//--- hw/rename_output.sv
// Rename output stage with the renamed pair register and strobe

module rename_output
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    recover,
	input  logic                    decode_valid,
	input  rename_pkg::rename_out_t result,
	output logic                    rename_strobe,
	output rename_pkg::rename_out_t rename
);

	logic any_valid;

	// No bundle goes out when neither slot renamed anything
	assign any_valid = result.slot0.valid || result.slot1.valid;

	always_ff @(posedge clock)
	begin
		if (reset || recover)
			rename_strobe <= 1'b0;  // Flush drops the pair in flight
		else
			rename_strobe <= decode_valid && any_valid;
	end

	always_ff @(posedge clock)
	begin
		if (decode_valid)
			rename <= result;
	end

endmodule

//--- hw/rename_pkg.sv
// Rename types for register indices, physical tags, operand selects, dispatch and rename bundles

package rename_pkg;

	typedef logic [4:0] arch_reg_t;
	typedef logic [6:0] phys_tag_t;  // Up to 128 physical registers

	// Always mapped to tag 0 and always ready
	localparam arch_reg_t zero_reg = 5'd0;

	typedef enum logic [1:0]
	{
		opa_is_rega = 2'h0,
		opa_is_npc  = 2'h1,
		opa_is_pc   = 2'h2,
		opa_is_zero = 2'h3
	} opa_sel_e;

	typedef enum logic [1:0]
	{
		opb_is_regb    = 2'h0,
		opb_is_imm     = 2'h1,
		opb_is_br_disp = 2'h2,
		opb_is_zero    = 2'h3
	} opb_sel_e;

	// One decoded instruction as seen by rename
	typedef struct packed
	{
		logic      valid;  // After decode this means the slot needs a dest tag
		opa_sel_e  opa_sel;
		opb_sel_e  opb_sel;
		arch_reg_t src_a;
		arch_reg_t src_b;
		arch_reg_t dest;
	} rename_req_t;

	typedef struct packed
	{
		rename_req_t slot1;
		rename_req_t slot0;  // Older instruction
	} dispatch_t;

	// Renamed instruction for the reservation station and the ROB
	typedef struct packed
	{
		logic      valid;
		phys_tag_t src_a_tag;
		logic      src_a_ready;
		phys_tag_t src_b_tag;
		logic      src_b_ready;
		arch_reg_t dest;
		phys_tag_t dest_tag;
		phys_tag_t told_tag;  // Previous mapping that is freed at retire
	} rename_slot_t;

	typedef struct packed
	{
		rename_slot_t slot1;
		rename_slot_t slot0;
	} rename_out_t;

endpackage

//--- hw/rename_top.sv
// Rename stage top level with decode, free list, map table and output register

module rename_top
#(
	parameter int num_pr    = 96,
	parameter int cdb_width = 4
)
(
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                dispatch_strobe,
	input  rename_pkg::dispatch_t               dispatch,
	input  cdb_pkg::cdb_entry_t [cdb_width-1:0] cdb,
	input  cdb_pkg::retire_entry_t [1:0]        retire,
	input  logic                                recover,
	output logic                                rename_strobe,
	output rename_pkg::rename_out_t             rename
);

	import rename_pkg::*;

	logic        decode_valid;
	dispatch_t   stage;
	phys_tag_t   new_tag0;
	phys_tag_t   new_tag1;
	rename_out_t result;

	// Cycle 1
	rename_decode decode0
	(
		.clock           (clock),
		.reset           (reset),
		.recover         (recover),
		.dispatch_strobe (dispatch_strobe),
		.dispatch        (dispatch),
		.decode_valid    (decode_valid),
		.stage           (stage)
	);

	free_list #(.num_pr(num_pr)) free_list0
	(
		.clock        (clock),
		.reset        (reset),
		.recover      (recover),
		.decode_valid (decode_valid),
		.stage        (stage),
		.retire       (retire),
		.new_tag0     (new_tag0),
		.new_tag1     (new_tag1)
	);

	map_table #(.num_pr(num_pr), .cdb_width(cdb_width)) map_table0
	(
		.clock        (clock),
		.reset        (reset),
		.recover      (recover),
		.decode_valid (decode_valid),
		.stage        (stage),
		.new_tag0     (new_tag0),
		.new_tag1     (new_tag1),
		.cdb          (cdb),
		.retire       (retire),
		.result       (result)
	);

	// Cycle 2
	rename_output output0
	(
		.clock         (clock),
		.reset         (reset),
		.recover       (recover),
		.decode_valid  (decode_valid),
		.result        (result),
		.rename_strobe (rename_strobe),
		.rename        (rename)
	);

endmodule

//--- tb.f
+incdir+dv
hw/rename_pkg.sv
hw/cdb_pkg.sv
hw/rename_decode.sv
hw/free_list.sv
hw/map_table.sv
hw/rename_output.sv
hw/rename_top.sv
dv/rename_tb.sv
